//--- include/l2_consts.svh
// L2 memory constants
// Bank count, bank depth and the address and data widths of the
// interleaved L2 memory

`ifndef L2_CONSTS_SVH
`define L2_CONSTS_SVH

// Interleaved banks and the address bits that pick one
`define L2_NB_BANKS         4
`define L2_BANK_SEL_WIDTH   2

// Depth of a single bank in words
`define L2_BANK_WORDS       256
`define L2_BANK_ADDR_WIDTH  8

// Word address seen on the external port
// bank select in the low bits, bank index above it
`define L2_WORD_ADDR_WIDTH  10

// Data word and byte enables
`define L2_DATA_WIDTH       32
`define L2_BE_WIDTH         4

`endif

//--- hw/l2_mem_pkg.sv
// L2 memory bus types
// Vector types for data, byte enables and the word, bank and
// bank select addresses of the interleaved L2 memory

`include "l2_consts.svh"

package l2_mem_pkg;

   // One data word and its byte enables where bit n enables byte n
   typedef logic [`L2_DATA_WIDTH-1:0]      l2_data_t;
   typedef logic [`L2_BE_WIDTH-1:0]        l2_be_t;

   // Full word address of the external port
   typedef logic [`L2_WORD_ADDR_WIDTH-1:0] l2_word_addr_t;

   // Word index inside one bank
   typedef logic [`L2_BANK_ADDR_WIDTH-1:0] l2_bank_addr_t;

   // Bank number taken from the low address bits
   typedef logic [`L2_BANK_SEL_WIDTH-1:0]  l2_bank_sel_t;

endpackage

//--- hw/l2_ctrl_pkg.sv
// L2 init controller types
// State encoding of the clear sequencer and the sweep index type

`include "l2_consts.svh"

package l2_ctrl_pkg;

   typedef enum logic [1:0] {
      INIT_IDLE,
      INIT_CLEAR,
      INIT_DONE
   } l2_init_state_t;

   // Same meaning as a bank word index
   typedef logic [`L2_BANK_ADDR_WIDTH-1:0] l2_init_idx_t;

endpackage

//--- hw/l2_mem_bus_if.sv
// L2 bank bus
// Signals of one single-port bank: active-low chip select and write
// enable, byte enables, word index, write data and read data

`timescale 1ns/1ps

interface l2_mem_bus_if
   import l2_mem_pkg::*;
();

   logic          csn;
   logic          wen;
   l2_be_t        be;
   l2_bank_addr_t add;
   l2_data_t      wdata;
   l2_data_t      rdata;

   // Request side
   modport master (output csn, wen, be, add, wdata, input rdata);

   // Bank side
   modport slave (input csn, wen, be, add, wdata, output rdata);

endinterface

//--- hw/l2_bank.sv
// L2 bank
// Behavioral single-port RAM with byte-enable writes and a read port
// registered for one cycle

`timescale 1ns/1ps

`include "l2_consts.svh"

module l2_bank
   import l2_mem_pkg::*;
(
   input logic         clk_i,
   l2_mem_bus_if.slave bus
);

   l2_data_t mem_q [`L2_BANK_WORDS];
   l2_data_t rdata_q;

   // Request when csn is low, write when wen is low as well
   always_ff @(posedge clk_i)
   begin
      if (!bus.csn)
      begin
         if (!bus.wen)
         begin
            for (int b = 0; b < `L2_BE_WIDTH; b++)
            begin
               if (bus.be[b])
               begin
                  mem_q[bus.add][8*b +: 8] <= bus.wdata[8*b +: 8];
               end
            end
         end
         else
         begin
            rdata_q <= mem_q[bus.add];
         end
      end
   end

   // Holds the last read word until the next read
   assign bus.rdata = rdata_q;

endmodule

//--- hw/l2_ram_multi_bank.sv
// L2 bank array
// One behavioral bank per interleaved bank bus

`timescale 1ns/1ps

`include "l2_consts.svh"

module l2_ram_multi_bank (
   input logic         clk_i,
   l2_mem_bus_if.slave bank_bus [`L2_NB_BANKS-1:0]
);

   // Bank i serves the word addresses whose low bits are i
   for (genvar i = 0; i < `L2_NB_BANKS; i++)
   begin : cuts
      l2_bank bank_i (
         .clk_i ( clk_i       ),
         .bus   ( bank_bus[i] )
      );
   end

endmodule

//--- hw/l2_bank_router.sv
// L2 bank router
// Splits the interleaved word address into bank select and bank index,
// drives the bank buses, replaces external traffic with zero writes
// while clearing, and returns the read word of the bank that was read

`timescale 1ns/1ps

`include "l2_consts.svh"

module l2_bank_router
   import l2_mem_pkg::*;
   import l2_ctrl_pkg::*;
(
   input  logic          clk_i,
   input  logic          reset_i,
   input  logic          csn_i,
   input  logic          wen_i,
   input  l2_be_t        be_i,
   input  l2_word_addr_t addr_i,
   input  l2_data_t      wdata_i,
   input  logic          clear_en_i,
   input  l2_init_idx_t  clear_idx_i,
   output l2_data_t      rdata_o,
   l2_mem_bus_if.master  bank_bus [`L2_NB_BANKS-1:0]
);

   l2_bank_sel_t  req_sel;
   l2_bank_addr_t req_add;
   logic          ext_req;
   logic          ext_rd;
   logic          rd_pending_q;
   l2_bank_sel_t  rd_sel_q;
   l2_data_t      bank_rdata [`L2_NB_BANKS];

   // Low bits pick the bank and the upper bits the word inside it
   assign req_sel = addr_i[`L2_BANK_SEL_WIDTH-1:0];
   assign req_add = addr_i[`L2_WORD_ADDR_WIDTH-1:`L2_BANK_SEL_WIDTH];

   // External port is dropped during the clear sweep
   assign ext_req = ~csn_i & ~clear_en_i;
   assign ext_rd  = ext_req & wen_i;

   for (genvar b = 0; b < `L2_NB_BANKS; b++)
   begin : g_bank
      // Clear writes zero to the same index in every bank
      assign bank_bus[b].csn   = ~(clear_en_i | (ext_req & (req_sel == l2_bank_sel_t'(b))));
      assign bank_bus[b].wen   = clear_en_i ? 1'b0 : wen_i;
      assign bank_bus[b].be    = clear_en_i ? '1 : be_i;
      assign bank_bus[b].add   = clear_en_i ? clear_idx_i : req_add;
      assign bank_bus[b].wdata = clear_en_i ? '0 : wdata_i;

      assign bank_rdata[b] = bank_bus[b].rdata;
   end

   // Bank data is valid one cycle after the read edge
   // and is captured into rdata_o on the following edge
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rd_pending_q <= 1'b0;
         rd_sel_q     <= '0;
         rdata_o      <= '0;
      end
      else
      begin
         rd_pending_q <= ext_rd;
         if (ext_rd)
         begin
            rd_sel_q <= req_sel;
         end
         if (rd_pending_q)
         begin
            rdata_o <= bank_rdata[rd_sel_q];
         end
      end
   end

endmodule

//--- hw/l2_init_fsm.sv
// L2 init sequencer
// Runs the clear sweep after an init pulse and reports busy and done

`timescale 1ns/1ps

module l2_init_fsm
   import l2_ctrl_pkg::*;
(
   input  logic clk_i,
   input  logic reset_i,
   input  logic init_i,
   input  logic last_i,
   output logic clear_en_o,
   output logic busy_o,
   output logic init_done_o
);

   l2_init_state_t state_q;
   l2_init_state_t state_d;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         INIT_IDLE, INIT_DONE:
         begin
            if (init_i)
            begin
               state_d = INIT_CLEAR;
            end
         end
         // init_i is ignored until the sweep ends
         INIT_CLEAR:
         begin
            if (last_i)
            begin
               state_d = INIT_DONE;
            end
         end
         default: state_d = INIT_IDLE;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_q <= INIT_IDLE;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   assign clear_en_o  = (state_q == INIT_CLEAR);
   assign busy_o      = (state_q == INIT_CLEAR);
   assign init_done_o = (state_q == INIT_DONE);

endmodule

//--- hw/l2_init_counter.sv
// L2 clear sweep counter
// Walks the bank word index during the clear and flags the last one

`timescale 1ns/1ps

`include "l2_consts.svh"

module l2_init_counter
   import l2_ctrl_pkg::*;
(
   input  logic         clk_i,
   input  logic         reset_i,
   input  logic         en_i,
   output l2_init_idx_t idx_o,
   output logic         last_o
);

   l2_init_idx_t idx_q;

   // Wraps after the last index so the next sweep starts at zero
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         idx_q <= '0;
      end
      else if (en_i)
      begin
         idx_q <= last_o ? '0 : idx_q + 1'b1;
      end
   end

   assign idx_o  = idx_q;
   assign last_o = (idx_q == l2_init_idx_t'(`L2_BANK_WORDS - 1));

endmodule

//--- hw/l2_mem_subsystem.sv
// L2 memory subsystem
// Four-bank interleaved L2 memory with a single word port and a
// clear sequencer that zeroes every word after an init pulse

`timescale 1ns/1ps

`include "l2_consts.svh"

module l2_mem_subsystem
   import l2_mem_pkg::*;
   import l2_ctrl_pkg::*;
(
   input  logic          clk_i,
   input  logic          reset_i,
   input  logic          init_i,
   input  logic          csn_i,
   input  logic          wen_i,
   input  l2_be_t        be_i,
   input  l2_word_addr_t addr_i,
   input  l2_data_t      wdata_i,
   output l2_data_t      rdata_o,
   output logic          busy_o,
   output logic          init_done_o
);

   logic         clear_en;
   logic         clear_last;
   l2_init_idx_t clear_idx;

   l2_mem_bus_if bank_bus [`L2_NB_BANKS-1:0] ();

   l2_init_fsm init_fsm_i (
      .clk_i       ( clk_i       ),
      .reset_i     ( reset_i     ),
      .init_i      ( init_i      ),
      .last_i      ( clear_last  ),
      .clear_en_o  ( clear_en    ),
      .busy_o      ( busy_o      ),
      .init_done_o ( init_done_o )
   );

   l2_init_counter init_counter_i (
      .clk_i   ( clk_i      ),
      .reset_i ( reset_i    ),
      .en_i    ( clear_en   ),
      .idx_o   ( clear_idx  ),
      .last_o  ( clear_last )
   );

   l2_bank_router bank_router_i (
      .clk_i       ( clk_i     ),
      .reset_i     ( reset_i   ),
      .csn_i       ( csn_i     ),
      .wen_i       ( wen_i     ),
      .be_i        ( be_i      ),
      .addr_i      ( addr_i    ),
      .wdata_i     ( wdata_i   ),
      .clear_en_i  ( clear_en  ),
      .clear_idx_i ( clear_idx ),
      .rdata_o     ( rdata_o   ),
      .bank_bus    ( bank_bus  )
   );

   l2_ram_multi_bank ram_i (
      .clk_i    ( clk_i    ),
      .bank_bus ( bank_bus )
   );

endmodule

//--- verif/l2_mem_subsystem_sva.sv
// L2 memory subsystem assertions
// Clear sweep length, init done timing, bank selects in reset and
// read data latency, bound onto the subsystem top level

`timescale 1ns/1ps

`include "l2_consts.svh"

module l2_mem_subsystem_sva
   import l2_mem_pkg::*;
(
   input logic                    clk_i,
   input logic                    reset_i,
   input logic                    csn_i,
   input logic                    wen_i,
   input logic                    busy_i,
   input logic                    init_done_i,
   input l2_data_t                rdata_i,
   input logic [`L2_NB_BANKS-1:0] bank_csn_i
);

   int unsigned busy_cycles;
   logic        rd_req;

   // External read that reaches a bank
   assign rd_req = ~csn_i & wen_i & ~busy_i;

   // Cycles spent in the current sweep
   always_ff @(posedge clk_i)
   begin
      if (reset_i || !busy_i)
      begin
         busy_cycles <= 0;
      end
      else
      begin
         busy_cycles <= busy_cycles + 1;
      end
   end

   sweep_length_a : assert property (@(posedge clk_i) disable iff (reset_i)
      $fell(busy_i) |-> busy_cycles == `L2_BANK_WORDS)
      else $error("busy_o fell before or after one full sweep");

   sweep_bound_a : assert property (@(posedge clk_i) disable iff (reset_i)
      busy_i |-> busy_cycles < `L2_BANK_WORDS)
      else $error("busy_o stayed high past one full sweep");

   done_rise_a : assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(init_done_i) |-> $fell(busy_i))
      else $error("init_done_o rose without busy_o falling");

   reset_csn_a : assert property (@(posedge clk_i)
      reset_i && $past(reset_i) |-> &bank_csn_i)
      else $error("bank chip select active during reset");

   // rdata_o only moves two edges after a read request
   rdata_latency_a : assert property (@(posedge clk_i) disable iff (reset_i)
      !$stable(rdata_i) |-> $past(rd_req, 2))
      else $error("rdata_o changed without a read two cycles earlier");

endmodule

bind l2_mem_subsystem l2_mem_subsystem_sva sva_i (
   .clk_i       ( clk_i       ),
   .reset_i     ( reset_i     ),
   .csn_i       ( csn_i       ),
   .wen_i       ( wen_i       ),
   .busy_i      ( busy_o      ),
   .init_done_i ( init_done_o ),
   .rdata_i     ( rdata_o     ),
   .bank_csn_i  ( {bank_bus[3].csn, bank_bus[2].csn, bank_bus[1].csn, bank_bus[0].csn} )
);

//--- verif/l2_mem_subsystem_tb.sv
// L2 memory subsystem testbench
// Directed tests of reset, clear sweep, bank interleaving, byte enables,
// random traffic and re-init against a word-level reference model

`timescale 1ns/1ps

`include "l2_consts.svh"

module l2_mem_subsystem_tb
   import l2_mem_pkg::*;
();

   localparam int          CLK_PERIOD      = 8;
   localparam int          NB_WORDS        = 1 << `L2_WORD_ADDR_WIDTH;
   localparam int          RANDOM_OPS      = 400;
   localparam int          RANDOM_BASE     = 512;
   localparam int          RANDOM_SPAN     = 32;
   localparam int          WATCHDOG_CYCLES = 6 * `L2_BANK_WORDS + 4 * NB_WORDS + 2 * RANDOM_OPS;
   localparam logic [31:0] RANDOM_SEED     = 32'ha8a7c3f5;

   logic          clk_i;
   logic          reset_i;
   logic          init_i;
   logic          csn_i;
   logic          wen_i;
   l2_be_t        be_i;
   l2_word_addr_t addr_i;
   l2_data_t      wdata_i;
   l2_data_t      rdata_o;
   logic          busy_o;
   logic          init_done_o;

   // Reference model and the read waiting for its data
   l2_data_t      model [NB_WORDS];
   logic          rd_pending;
   l2_data_t      rd_expect;
   int            errors;
   int            checks;

   l2_mem_subsystem l2_mem_subsystem_inst (
      .clk_i       ( clk_i       ),
      .reset_i     ( reset_i     ),
      .init_i      ( init_i      ),
      .csn_i       ( csn_i       ),
      .wen_i       ( wen_i       ),
      .be_i        ( be_i        ),
      .addr_i      ( addr_i      ),
      .wdata_i     ( wdata_i     ),
      .rdata_o     ( rdata_o     ),
      .busy_o      ( busy_o      ),
      .init_done_o ( init_done_o )
   );

   initial
   begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Test FAILED");
      $finish;
   end

   task automatic check_data(input string name, input l2_data_t expected, input l2_data_t actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("error at %0t ns: %s expected %b, actual %b", $time, name, expected, actual);
      end
   endtask

   task automatic compare_count(input string name, input int expected, input int actual);
      checks++;
      if (actual != expected)
      begin
         errors++;
         $display("error at %0t ns: %s expected %0d, actual %0d", $time, name, expected, actual);
      end
   endtask

   task automatic drive_idle();
      csn_i   = 1'b1;
      wen_i   = 1'b1;
      be_i    = '0;
      addr_i  = '0;
      wdata_i = '0;
   endtask

   // Read data shows up one cycle after the read edge
   task automatic finish_read();
      if (rd_pending)
      begin
         check_data("rdata_o", rd_expect, rdata_o);
         rd_pending = 1'b0;
      end
   endtask

   task automatic idle_cycle();
      @(posedge clk_i);
      #1;
      finish_read();
   endtask

   task automatic write_word(input l2_word_addr_t addr, input l2_be_t be, input l2_data_t data);
      csn_i   = 1'b0;
      wen_i   = 1'b0;
      be_i    = be;
      addr_i  = addr;
      wdata_i = data;
      @(posedge clk_i);
      #1;
      finish_read();
      for (int b = 0; b < `L2_BE_WIDTH; b++)
      begin
         if (be[b])
         begin
            model[addr][8*b +: 8] = data[8*b +: 8];
         end
      end
      drive_idle();
   endtask

   task automatic read_word(input l2_word_addr_t addr);
      csn_i  = 1'b0;
      wen_i  = 1'b1;
      be_i   = '0;
      addr_i = addr;
      @(posedge clk_i);
      #1;
      finish_read();
      rd_pending = 1'b1;
      rd_expect  = model[addr];
      drive_idle();
   endtask

   task automatic read_all_words();
      for (int i = 0; i < NB_WORDS; i++)
      begin
         read_word(l2_word_addr_t'(i));
      end
      idle_cycle();
   endtask

   // Pulse init and count the busy cycles with an optional second pulse mid-sweep
   task automatic run_clear(input logic pulse_during_busy);
      int busy_cycles;
      init_i = 1'b1;
      @(posedge clk_i);
      #1;
      init_i = 1'b0;
      check_flag("busy_o", 1'b1, busy_o);
      check_flag("init_done_o", 1'b0, init_done_o);
      busy_cycles = 0;
      while (busy_o === 1'b1 && busy_cycles <= 2 * `L2_BANK_WORDS)
      begin
         busy_cycles++;
         init_i = pulse_during_busy && (busy_cycles == `L2_BANK_WORDS / 2);
         @(posedge clk_i);
         #1;
      end
      init_i = 1'b0;
      compare_count("busy_o cycles", `L2_BANK_WORDS, busy_cycles);
      check_flag("busy_o", 1'b0, busy_o);
      check_flag("init_done_o", 1'b1, init_done_o);
      for (int i = 0; i < NB_WORDS; i++)
      begin
         model[i] = '0;
      end
   endtask

   task automatic reset_values();
      check_flag("busy_o", 1'b0, busy_o);
      check_flag("init_done_o", 1'b0, init_done_o);
      check_data("rdata_o", '0, rdata_o);
   endtask

   task automatic clear_sweep();
      run_clear(1'b0);
      read_all_words();
   endtask

   // Consecutive words land in consecutive banks
   task automatic bank_interleave();
      for (int i = 0; i < 16; i++)
      begin
         write_word(l2_word_addr_t'(256 + i), '1, $urandom);
      end
      for (int i = 15; i >= 0; i--)
      begin
         read_word(l2_word_addr_t'(256 + i));
      end
      for (int b = 0; b < `L2_NB_BANKS; b++)
      begin
         for (int k = 0; k < 4; k++)
         begin
            read_word(l2_word_addr_t'(256 + 4 * k + b));
         end
      end
      idle_cycle();
   endtask

   task automatic byte_enable_merge();
      for (int i = 0; i < 16; i++)
      begin
         write_word(l2_word_addr_t'(768 + i), '1, 32'h8c4e_1d70 + i);
         write_word(l2_word_addr_t'(768 + i), l2_be_t'(i), 32'ha5c3_3ca5);
      end
      for (int i = 0; i < 16; i++)
      begin
         read_word(l2_word_addr_t'(768 + i));
      end
      idle_cycle();
   endtask

   task automatic random_traffic();
      l2_word_addr_t addr;
      logic          last_write;
      addr       = '0;
      last_write = 1'b0;
      for (int n = 0; n < RANDOM_OPS; n++)
      begin
         if (last_write && (($urandom % 3) == 0))
         begin
            // Same address in the cycle right after its write
            read_word(addr);
            last_write = 1'b0;
         end
         else
         begin
            addr = l2_word_addr_t'(RANDOM_BASE + ($urandom % RANDOM_SPAN));
            last_write = (($urandom % 2) == 0);
            if (last_write)
            begin
               write_word(addr, l2_be_t'($urandom), $urandom);
            end
            else
            begin
               read_word(addr);
            end
         end
      end
      idle_cycle();
   endtask

   task automatic reinit_sweep();
      check_flag("init_done_o", 1'b1, init_done_o);
      run_clear(1'b1);
      read_all_words();
   endtask

   initial
   begin
      void'($urandom(RANDOM_SEED));
      errors     = 0;
      checks     = 0;
      rd_pending = 1'b0;
      rd_expect  = '0;
      reset_i    = 1'b1;
      init_i     = 1'b0;
      drive_idle();
      repeat (4) @(posedge clk_i);
      #1;
      reset_i = 1'b0;

      reset_values();
      clear_sweep();
      bank_interleave();
      byte_enable_merge();
      random_traffic();
      reinit_sweep();

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Test OK");
      end
      else
      begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- sources.f
+incdir+include
hw/l2_mem_pkg.sv
hw/l2_ctrl_pkg.sv
hw/l2_mem_bus_if.sv
hw/l2_bank.sv
hw/l2_ram_multi_bank.sv
hw/l2_bank_router.sv
hw/l2_init_fsm.sv
hw/l2_init_counter.sv
hw/l2_mem_subsystem.sv
verif/l2_mem_subsystem_sva.sv
verif/l2_mem_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the L2 memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module l2_mem_subsystem_tb -o l2_sim

status=0
output=$(./obj_dir/l2_sim) || status=$?
echo "$output"

if [ "$status" -ne 0 ] || ! grep -qx "Test OK" <<< "$output"; then
   exit 1
fi
exit 0
